//--- saturnGlue.f
hdl/saturnGluePkg.sv
hdl/busReadSelect.sv
hdl/glueClockGen.sv
hdl/smpcTick.sv
hdl/cpuBusGlue.sv
hdl/busMonitor.sv
hdl/saturnGlue.sv
tb/saturnGlue_assert.sv
tb/saturnGlueTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the saturnGlue testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module saturnGlueTb \
	-f saturnGlue.f -o saturnGlueSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/saturnGlueSim > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tb/saturnGlueStim.mem
// code arg sel exp, four hex words per vector
// code 1 phase, 2 break, 3 tick, 4 CPU read and wait, 5 B-bus read, 6 monitor
0001 0008 0000 0000
0001 0006 0001 0000
0002 0004 0000 0000
0003 0002 0000 0007
0004 0004 003F 0001
0004 0004 003E 0000
0004 0004 005A 0000
0004 0004 006F 0001
0004 0004 0075 0000
0004 0004 007A 0011
0004 0004 0079 0010
0004 0004 007E 0021
0004 0004 007D 0020
0005 0004 0006 0000
0005 0004 0004 0000
0005 0004 0005 0001
0005 0004 0001 0001
0005 0004 0003 0002
0005 0004 0007 0003
0005 0004 0000 0000
0006 0001 0000 0000
0006 0005 0004 0000
0006 000C 0000 0000
0006 0002 0003 0000
0006 0003 0002 0001
0006 0001 0003 0001

//--- tb/saturnGlueTb.sv
`timescale 1ns/1ps
`default_nettype none

module saturnGlueTb;

	logic CLK;
	logic RST_N;
	logic ce;
	logic dbgPause;
	logic dbgBreak;
	logic dbgRun;
	logic vdp1Start;
	logic vdp1CmdEnd;
	saturnGluePkg::addrT cpuAddr;
	logic cpuRdN;
	saturnGluePkg::dqmT cpuDqmN;
	logic cs3N, dramCeN, romCeN, sramCeN, smpcCeN;
	saturnGluePkg::wordT memDi;
	saturnGluePkg::byteT smpcDo;
	saturnGluePkg::wordT scuDo;
	logic scuWaitN, memWaitN;
	logic bcs1N, bcs2N, bcssN;
	saturnGluePkg::halfT vdp1Do, vdp2Do, scspDo;
	logic ceR, ceF, paused, smpcCe, mresN;
	saturnGluePkg::wordT cpuDi;
	logic cpuWaitN;
	saturnGluePkg::halfT bDi;
	saturnGluePkg::waitCntT dbgWaitCnt;
	logic dbgHook;

	// Four words per vector for code, argument, selects and expected
	logic [15:0] stim [256];
	int numVectors;
	int errors;
	integer seed;
	logic tickSeen;

	saturnGlue saturnGlue_i (.*);

	always #2 CLK = ~CLK;

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("error %s: expected %0h, actual %0h", testName, expected, actual);
		errors++;
	endtask

	task automatic reportFailure(input string text);
		$display("%s", text);
		errors++;
	endtask

	task automatic driveIdle();
		{cs3N, dramCeN, romCeN, sramCeN, smpcCeN} = 5'b11111;
		{scuWaitN, memWaitN} = 2'b11;
		{bcssN, bcs2N, bcs1N} = 3'b111;
		cpuAddr = '0;
		cpuRdN = 1'b1;
		cpuDqmN = 4'hF;
	endtask

	// Returns on the falling edge after a rising edge that saw ceR
	task automatic waitForCeR();
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			seen = ceR;
			@(negedge CLK);
		end
	endtask

	task automatic phaseTest(input int cycles, input logic pause);
		logic expPhase;
		expPhase = ceR;
		dbgPause = pause;
		repeat (cycles) begin
			if (!pause) begin
				expPhase = !expPhase;
			end
			@(negedge CLK);
			if (pause && (ceR || ceF)) begin
				reportMismatch("phase paused", 32'h0, 32'({ceR, ceF}));
			end
			if (!pause && (ceR !== expPhase || ceF !== !expPhase)) begin
				reportMismatch("phase toggle", 32'({expPhase, !expPhase}), 32'({ceR, ceF}));
			end
		end
		dbgPause = 1'b0;
		// Held phase shows again as soon as the pause drops
		#1;
		if (ceR !== expPhase || ceF !== !expPhase) begin
			reportMismatch("phase hold", 32'({expPhase, !expPhase}), 32'({ceR, ceF}));
		end
		expPhase = !expPhase;
		@(negedge CLK);
		if (ceR !== expPhase) begin
			reportMismatch("phase resume", 32'(expPhase), 32'(ceR));
		end
	endtask

	task automatic waitPaused(input string testName);
		int n;
		n = 0;
		while (!paused && n < 2) begin
			@(negedge CLK);
			n++;
		end
		if (!paused) begin
			reportFailure($sformatf("%s: paused did not rise within two cycles", testName));
		end
	endtask

	task automatic clearBreak(input string testName);
		dbgBreak = 1'b0;
		dbgRun = 1'b1;
		@(negedge CLK);
		dbgRun = 1'b0;
		if (paused !== 1'b0) begin
			reportMismatch(testName, 32'h0, 32'(paused));
		end
	endtask

	task automatic breakTest(input int holdCycles);
		dbgBreak = 1'b1;
		vdp1Start = 1'b1;
		@(negedge CLK);
		vdp1Start = 1'b0;
		waitPaused("break start");
		repeat (holdCycles) begin
			@(negedge CLK);
			if (!paused || ceR || ceF) begin
				reportMismatch("break hold", 32'h4, 32'({paused, ceR, ceF}));
			end
		end
		clearBreak("break run");
		// Command end arms the break now that a start was seen
		dbgBreak = 1'b1;
		vdp1CmdEnd = 1'b1;
		@(negedge CLK);
		vdp1CmdEnd = 1'b0;
		waitPaused("break cmd end");
		clearBreak("break cmd end run");
	endtask

	task automatic tickTest(input int intervals, input int expPulses);
		int n;
		int count;
		n = 0;
		while (!smpcCe && n < 4 * expPulses) begin
			@(negedge CLK);
			n++;
		end
		if (!smpcCe) begin
			reportFailure($sformatf("tick: no smpcCe pulse within %0d cycles", n));
		end else begin
			repeat (intervals) begin
				count = 0;
				n = 0;
				@(negedge CLK);
				if (smpcCe) begin
					reportMismatch("tick width", 32'h0, 32'h1);
				end
				while (!smpcCe && n < 4 * expPulses) begin
					if (ceR) begin
						count++;
					end
					@(negedge CLK);
					n++;
				end
				if (count != expPulses) begin
					reportMismatch("tick ceR per smpcCe", 32'(expPulses), 32'(count));
				end
			end
		end
	endtask

	task automatic cpuTest(input int reps, input logic [15:0] sel, input logic [15:0] expv);
		saturnGluePkg::wordT expData;
		repeat (reps) begin
			memDi = $random(seed);
			smpcDo = saturnGluePkg::byteT'($random(seed));
			scuDo = $random(seed);
			{cs3N, dramCeN, romCeN, sramCeN, smpcCeN, scuWaitN, memWaitN} = sel[6:0];
			case (expv[5:4])
				2'd0: expData = memDi;
				2'd1: expData = {4{smpcDo}};
				default: expData = scuDo;
			endcase
			@(negedge CLK);
			if (cpuDi !== expData) begin
				reportMismatch("cpu read", expData, cpuDi);
			end
			if (cpuWaitN !== expv[0]) begin
				reportMismatch("cpu wait", 32'(expv[0]), 32'(cpuWaitN));
			end
		end
		driveIdle();
	endtask

	task automatic bBusTest(input int reps, input logic [15:0] sel, input logic [15:0] expSrc);
		saturnGluePkg::halfT expData;
		repeat (reps) begin
			vdp1Do = saturnGluePkg::halfT'($random(seed));
			vdp2Do = saturnGluePkg::halfT'($random(seed));
			scspDo = saturnGluePkg::halfT'($random(seed));
			{bcssN, bcs2N, bcs1N} = sel[2:0];
			case (expSrc[1:0])
				2'd0: expData = vdp1Do;
				2'd1: expData = vdp2Do;
				2'd2: expData = scspDo;
				default: expData = '0;
			endcase
			@(negedge CLK);
			if (bDi !== expData) begin
				reportMismatch("bbus read", 32'(expData), 32'(bDi));
			end
		end
		driveIdle();
	endtask

	task automatic monitorTest(input int pulses, input logic [15:0] sel, input logic expHook);
		saturnGluePkg::addrT addr;
		addr = saturnGluePkg::addrT'($random(seed));
		if (addr == saturnGluePkg::hookAddr) begin
			addr = addr ^ 25'h1;
		end
		waitForCeR();
		cpuAddr = addr;
		if (sel[2]) begin
			cpuDqmN = saturnGluePkg::dqmT'($random(seed)) & 4'hE;
		end else begin
			cpuRdN = 1'b0;
		end
		repeat (pulses) waitForCeR();
		driveIdle();
		if (dbgWaitCnt !== saturnGluePkg::waitCntT'(pulses)) begin
			reportMismatch("monitor count", 32'(pulses), 32'(dbgWaitCnt));
		end
		waitForCeR();
		if (dbgWaitCnt !== '0) begin
			reportMismatch("monitor clear", 32'h0, 32'(dbgWaitCnt));
		end
		if (sel[1]) begin
			cpuAddr = saturnGluePkg::hookAddr;
			cs3N = sel[0];
			cpuRdN = 1'b0;
			waitForCeR();
			driveIdle();
			waitForCeR();
		end
		if (dbgHook !== expHook) begin
			reportMismatch("monitor hook", 32'(expHook), 32'(dbgHook));
		end
	endtask

	// Manager reset follows the first tick
	always @(negedge CLK) begin
		if (RST_N) begin
			if (tickSeen && !mresN) begin
				reportMismatch("mresN after tick", 32'h1, 32'h0);
			end
			if (!tickSeen && mresN) begin
				reportMismatch("mresN before tick", 32'h0, 32'h1);
			end
			if (smpcCe) begin
				tickSeen = 1'b1;
			end
		end
	end

	initial begin
		wait (numVectors > 0);
		// 4 ns per cycle
		#((numVectors * 64 + 20) * 4);
		$display("Timeout: the tests did not finish in time, %0d errors so far", errors);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [15:0] code;
		logic [15:0] sel;
		logic [15:0] expv;
		int arg;
		CLK = 1'b0;
		RST_N = 1'b0;
		ce = 1'b1;
		dbgPause = 1'b0;
		dbgBreak = 1'b0;
		dbgRun = 1'b0;
		vdp1Start = 1'b0;
		vdp1CmdEnd = 1'b0;
		memDi = '0;
		smpcDo = '0;
		scuDo = '0;
		vdp1Do = '0;
		vdp2Do = '0;
		scspDo = '0;
		driveIdle();
		errors = 0;
		numVectors = 0;
		tickSeen = 1'b0;
		seed = 32'h649e_d535;
		foreach (stim[i]) begin
			stim[i] = '0;
		end
		$readmemh("tb/saturnGlueStim.mem", stim);
		while (numVectors < 64 && stim[4 * numVectors] != 16'h0) begin
			numVectors++;
		end
		if (numVectors == 0) begin
			reportFailure("No vectors read from the stimulus file");
		end
		repeat (10) @(negedge CLK);
		RST_N = 1'b1;
		for (int v = 0; v < numVectors; v++) begin
			code = stim[4 * v];
			arg = int'(stim[4 * v + 1]);
			sel = stim[4 * v + 2];
			expv = stim[4 * v + 3];
			case (code)
				16'h1: phaseTest(arg, sel[0]);
				16'h2: breakTest(arg);
				16'h3: tickTest(arg, int'(expv));
				16'h4: cpuTest(arg, sel, expv);
				16'h5: bBusTest(arg, sel, expv);
				16'h6: monitorTest(arg, sel, expv[0]);
				default: reportFailure($sformatf("Vector %0d has unknown test code %0h", v, code));
			endcase
		end
		$display("Vectors run: %0d, errors: %0d", numVectors, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/saturnGlue_assert.sv
`timescale 1ns/1ps
`default_nettype none

module saturnGlueAssert (
	input wire logic CLK,
	input wire logic RST_N,
	input wire logic ceR,
	input wire logic ceF,
	input wire logic paused,
	input wire logic smpcCe,
	input wire logic dbgHook
);

	phaseExclusive: assert property (@(posedge CLK) disable iff (!RST_N) !(ceR && ceF))
		else $error("ceR and ceF high in the same cycle");

	pauseSilent: assert property (@(posedge CLK) disable iff (!RST_N) paused |-> !ceR && !ceF)
		else $error("phase enable high while paused");

	// Manager tick is a single-cycle pulse
	tickSingle: assert property (@(posedge CLK) disable iff (!RST_N) smpcCe |=> !smpcCe)
		else $error("smpcCe high for two cycles");

	hookSticky: assert property (@(posedge CLK) disable iff (!RST_N) !$fell(dbgHook))
		else $error("dbgHook fell outside reset");

endmodule

bind saturnGlue saturnGlueAssert saturnGlueAssert_i (.*);

`default_nettype wire

//--- hdl/saturnGlue.sv
`timescale 1ns/1ps
`default_nettype none

module saturnGlue (
	input  wire logic              CLK,
	input  wire logic              RST_N,
	input  wire logic              ce,
	input  wire logic              dbgPause,
	input  wire logic              dbgBreak,
	input  wire logic              dbgRun,
	input  wire logic              vdp1Start,
	input  wire logic              vdp1CmdEnd,
	input  saturnGluePkg::addrT    cpuAddr,
	input  wire logic              cpuRdN,
	input  saturnGluePkg::dqmT     cpuDqmN,
	input  wire logic              cs3N,
	input  wire logic              dramCeN,
	input  wire logic              romCeN,
	input  wire logic              sramCeN,
	input  wire logic              smpcCeN,
	input  saturnGluePkg::wordT    memDi,
	input  saturnGluePkg::byteT    smpcDo,
	input  saturnGluePkg::wordT    scuDo,
	input  wire logic              scuWaitN,
	input  wire logic              memWaitN,
	input  wire logic              bcs1N,
	input  wire logic              bcs2N,
	input  wire logic              bcssN,
	input  saturnGluePkg::halfT    vdp1Do,
	input  saturnGluePkg::halfT    vdp2Do,
	input  saturnGluePkg::halfT    scspDo,
	output logic                   ceR,
	output logic                   ceF,
	output logic                   paused,
	output logic                   smpcCe,
	output logic                   mresN,
	output saturnGluePkg::wordT    cpuDi,
	output logic                   cpuWaitN,
	output saturnGluePkg::halfT    bDi,
	output saturnGluePkg::waitCntT dbgWaitCnt,
	output logic                   dbgHook
);

	logic [saturnGluePkg::bBusSources-1:0] bSelN;
	saturnGluePkg::halfT bData [saturnGluePkg::bBusSources];

	glueClockGen clockGen_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce(ce),
		.dbgPause(dbgPause),
		.dbgBreak(dbgBreak),
		.dbgRun(dbgRun),
		.vdp1Start(vdp1Start),
		.vdp1CmdEnd(vdp1CmdEnd),
		.ceR(ceR),
		.ceF(ceF),
		.paused(paused)
	);

	smpcTick smpcTick_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.smpcCe(smpcCe),
		.mresN(mresN)
	);

	cpuBusGlue cpuBusGlue_i (
		.cs3N(cs3N),
		.dramCeN(dramCeN),
		.romCeN(romCeN),
		.sramCeN(sramCeN),
		.smpcCeN(smpcCeN),
		.memDi(memDi),
		.smpcDo(smpcDo),
		.scuDo(scuDo),
		.scuWaitN(scuWaitN),
		.memWaitN(memWaitN),
		.cpuDi(cpuDi),
		.cpuWaitN(cpuWaitN)
	);

	// B-bus priority VDP1, VDP2, SCSP
	assign bSelN = {bcssN, bcs2N, bcs1N};
	assign bData[0] = vdp1Do;
	assign bData[1] = vdp2Do;
	assign bData[2] = scspDo;

	busReadSelect #(
		.payloadT(saturnGluePkg::halfT),
		.numSources(saturnGluePkg::bBusSources)
	) bBusSel_i (
		.selN(bSelN),
		.data(bData),
		.q(bDi)
	);

	busMonitor busMonitor_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.cpuAddr(cpuAddr),
		.cpuRdN(cpuRdN),
		.cpuDqmN(cpuDqmN),
		.cs3N(cs3N),
		.dbgWaitCnt(dbgWaitCnt),
		.dbgHook(dbgHook)
	);

endmodule

`default_nettype wire

//--- hdl/busMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module busMonitor (
	input  wire logic              CLK,
	input  wire logic              RST_N,
	input  wire logic              ceR,
	input  saturnGluePkg::addrT    cpuAddr,
	input  wire logic              cpuRdN,
	input  saturnGluePkg::dqmT     cpuDqmN,
	input  wire logic              cs3N,
	output saturnGluePkg::waitCntT dbgWaitCnt,
	output logic                   dbgHook
);

	logic accessActive;
	logic hookHit;

	// A read or any enabled byte lane
	assign accessActive = !cpuRdN || !(&cpuDqmN);
	assign hookHit = (cpuAddr == saturnGluePkg::hookAddr) && !cpuRdN && !cs3N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
			dbgHook <= 1'b0;
		end else if (ceR) begin
			if (accessActive) begin
				dbgWaitCnt <= dbgWaitCnt + 1'b1;
			end else begin
				dbgWaitCnt <= '0;
			end
			// Sticky until reset
			if (hookHit) begin
				dbgHook <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/cpuBusGlue.sv
`timescale 1ns/1ps
`default_nettype none

module cpuBusGlue (
	input  wire logic           cs3N,
	input  wire logic           dramCeN,
	input  wire logic           romCeN,
	input  wire logic           sramCeN,
	input  wire logic           smpcCeN,
	input  saturnGluePkg::wordT memDi,
	input  saturnGluePkg::byteT smpcDo,
	input  saturnGluePkg::wordT scuDo,
	input  wire logic           scuWaitN,
	input  wire logic           memWaitN,
	output saturnGluePkg::wordT cpuDi,
	output logic                cpuWaitN
);

	logic memSelN;
	logic [saturnGluePkg::cpuSources-1:0] selN;
	saturnGluePkg::wordT srcData [saturnGluePkg::cpuSources];

	// Any external memory region
	assign memSelN = cs3N & dramCeN & romCeN & sramCeN;

	// SCU is the fallback and is always selected
	assign selN = {1'b0, smpcCeN, memSelN};

	assign srcData[0] = memDi;
	assign srcData[1] = {4{smpcDo}};
	assign srcData[2] = scuDo;

	busReadSelect #(
		.payloadT(saturnGluePkg::wordT),
		.numSources(saturnGluePkg::cpuSources)
	) cpuReadSel_i (
		.selN(selN),
		.data(srcData),
		.q(cpuDi)
	);

	// Memory wait only counts while memory is addressed
	assign cpuWaitN = scuWaitN & (memWaitN | memSelN);

endmodule

`default_nettype wire

//--- hdl/smpcTick.sv
`timescale 1ns/1ps
`default_nettype none

module smpcTick (
	input  wire logic CLK,
	input  wire logic RST_N,
	input  wire logic ceR,
	output logic      smpcCe,
	output logic      mresN
);

	saturnGluePkg::smpcCntT cnt;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cnt <= '0;
			smpcCe <= 1'b0;
			mresN <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (ceR) begin
				if (cnt == saturnGluePkg::smpcCntT'(saturnGluePkg::smpcDivide - 1)) begin
					cnt <= '0;
					smpcCe <= 1'b1;
				end else begin
					cnt <= cnt + saturnGluePkg::smpcCntT'(1);
				end
			end
			// Manager leaves reset after its first tick
			if (smpcCe) begin
				mresN <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/glueClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module glueClockGen (
	input  wire logic CLK,
	input  wire logic RST_N,
	input  wire logic ce,
	input  wire logic dbgPause,
	input  wire logic dbgBreak,
	input  wire logic dbgRun,
	input  wire logic vdp1Start,
	input  wire logic vdp1CmdEnd,
	output logic      ceR,
	output logic      ceF,
	output logic      paused
);

	logic breakReg;
	logic started;
	logic phase;

	// Break arms on VDP1 start and on command end after a start
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			breakReg <= 1'b0;
			started <= 1'b0;
		end else begin
			if (vdp1Start) begin
				breakReg <= dbgBreak;
				started <= 1'b1;
			end else if (vdp1CmdEnd && started) begin
				breakReg <= dbgBreak;
			end else if (dbgRun) begin
				breakReg <= 1'b0;
			end
		end
	end

	assign paused = dbgPause | breakReg;

	// Phase holds while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (ce && !paused) begin
			phase <= ~phase;
		end
	end

	assign ceR = phase & ~paused;
	assign ceF = ~phase & ~paused;

endmodule

`default_nettype wire

//--- hdl/busReadSelect.sv
`timescale 1ns/1ps
`default_nettype none

module busReadSelect #(
	parameter type payloadT = saturnGluePkg::wordT,
	parameter int numSources = saturnGluePkg::cpuSources
) (
	input  wire logic [numSources-1:0] selN,
	input  payloadT                    data [numSources],
	output payloadT                    q
);

	// Walk from the last source down so the lowest index wins
	always_comb begin
		q = '0;
		for (int i = numSources - 1; i >= 0; i--) begin
			if (!selN[i]) begin
				q = data[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/saturnGluePkg.sv
`default_nettype none

package saturnGluePkg;

	// CPU side of the main bus
	typedef logic [24:0] addrT;
	typedef logic [31:0] wordT;
	typedef logic [3:0]  dqmT;

	// B-bus and system manager
	typedef logic [15:0] halfT;
	typedef logic [7:0]  byteT;

	typedef logic [7:0]  waitCntT;

	// Manager tick runs at one seventh of the rising phase rate
	localparam int smpcDivide = 7;
	typedef logic [$clog2(smpcDivide)-1:0] smpcCntT;

	// First word fetched by the boot code
	localparam addrT hookAddr = 25'h0012B0;

	localparam int bBusSources = 3;
	localparam int cpuSources  = 3;

endpackage

`default_nettype wire
